//--- include/yarc_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// platform address map and timer constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef YARC_DEFINES_SVH
`define YARC_DEFINES_SVH

// external data memory, whole 0x1xxx_xxxx region
`define YARC_DMEM_BASE          32'h1000_0000
`define YARC_DMEM_MASK          32'hF000_0000

// machine timer, 16 byte window
`define YARC_MTIMER_BASE        32'h2000_0000
`define YARC_MTIMER_MASK        32'hFFFF_FFF0

// led driver, single word
`define YARC_LED_BASE           32'h3000_0000
`define YARC_LED_MASK           32'hFFFF_FFFC

// clock cycles per mtime increment
`define YARC_MTIME_PRESCALE     1

// timer register word index, addr[3:2]
`define YARC_MTIME_LO_WORD      2'd0
`define YARC_MTIME_HI_WORD      2'd1
`define YARC_MTIMECMP_LO_WORD   2'd2
`define YARC_MTIMECMP_HI_WORD   2'd3

`endif

//--- src/platform_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared bus types for the platform
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package platform_pkg;

    // master to slave half of a pipelined wishbone link
    typedef struct packed
    {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] addr;
        // byte enables, one per wdata byte
        logic [3:0]  sel;
        logic [31:0] wdata;
    } wb_req_t;

    // slave to master half
    typedef struct packed
    {
        logic        ack;
        logic        err;
        // slave cannot take a request this cycle
        logic        stall;
        logic [31:0] rdata;
    } wb_rsp_t;

    // decoder target
    typedef enum logic [1:0]
    {
        SEL_DMEM,
        SEL_TIMER,
        SEL_LED,
        SEL_NONE
    } slave_sel_e;

    // arbiter grant
    typedef enum logic
    {
        OWN_CORE,
        OWN_DBG
    } bus_owner_e;

endpackage : platform_pkg

`default_nettype wire

//--- src/bus_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// round-robin arbiter, core and debug
// masters onto one shared data bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module bus_arbiter
(
    input  logic                 clk_i,
    input  logic                 rstn_i,

    // core data port
    input  platform_pkg::wb_req_t core_req_i,
    output platform_pkg::wb_rsp_t core_rsp_o,

    // debug port
    input  platform_pkg::wb_req_t dbg_req_i,
    output platform_pkg::wb_rsp_t dbg_rsp_o,

    // shared bus toward the decoder
    output platform_pkg::wb_req_t bus_req_o,
    input  platform_pkg::wb_rsp_t bus_rsp_i
);
    import platform_pkg::*;

    bus_owner_e owner_q;
    bus_owner_e owner_d;
    bus_owner_e last_q;
    bus_owner_e prev_winner;
    logic       grant_q;
    logic       grant_d;
    logic       bus_idle;
    wb_req_t    owner_req;

    // request of whoever holds the owner slot
    assign owner_req = (owner_q == OWN_CORE) ? core_req_i : dbg_req_i;

    // free when nobody holds it or the owner dropped cyc
    assign bus_idle = !grant_q || !owner_req.cyc;

    // current owner counts as the last winner while it holds the grant
    assign prev_winner = grant_q ? owner_q : last_q;

    always_comb
    begin
        owner_d = owner_q;
        grant_d = grant_q;

        if (bus_idle)
        begin
            grant_d = core_req_i.cyc || dbg_req_i.cyc;

            // tie goes to the master that did not win last time
            if (core_req_i.cyc && dbg_req_i.cyc)
                owner_d = (prev_winner == OWN_CORE) ? OWN_DBG : OWN_CORE;
            else if (core_req_i.cyc)
                owner_d = OWN_CORE;
            else if (dbg_req_i.cyc)
                owner_d = OWN_DBG;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            owner_q <= OWN_CORE;
            grant_q <= 1'b0;
            // debug counts as last so the core wins the first tie
            last_q  <= OWN_DBG;
        end
        else
        begin
            owner_q <= owner_d;
            grant_q <= grant_d;
            last_q  <= prev_winner;
        end
    end

    // only the owner reaches the bus, the other stb never leaves here
    assign bus_req_o = grant_q ? owner_req : '0;

    always_comb
    begin
        core_rsp_o = '0;
        dbg_rsp_o  = '0;

        // back-pressure for anyone waiting on the grant
        core_rsp_o.stall = core_req_i.cyc;
        dbg_rsp_o.stall  = dbg_req_i.cyc;

        if (grant_q)
        begin
            if (owner_q == OWN_CORE)
                core_rsp_o = bus_rsp_i;
            else
                dbg_rsp_o = bus_rsp_i;
        end
    end

endmodule : bus_arbiter

`default_nettype wire

//--- src/bus_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address decoder, routes the shared bus
// to dmem, timer or leds, errs on holes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "yarc_defines.svh"

module bus_decoder
(
    input  logic                 clk_i,
    input  logic                 rstn_i,

    // shared bus from the arbiter
    input  platform_pkg::wb_req_t bus_req_i,
    output platform_pkg::wb_rsp_t bus_rsp_o,

    // external data memory
    output platform_pkg::wb_req_t dmem_req_o,
    input  platform_pkg::wb_rsp_t dmem_rsp_i,

    // machine timer
    output platform_pkg::wb_req_t timer_req_o,
    input  platform_pkg::wb_rsp_t timer_rsp_i,

    // led driver
    output platform_pkg::wb_req_t led_req_o,
    input  platform_pkg::wb_rsp_t led_rsp_i
);
    import platform_pkg::*;

    slave_sel_e sel_d;
    slave_sel_e target_q;
    slave_sel_e route;
    logic       busy_q;
    logic       accept;
    logic       done;
    wb_rsp_t    tgt_rsp;

    // address compare, first match wins
    always_comb
    begin
        sel_d = SEL_NONE;

        if ((bus_req_i.addr & `YARC_DMEM_MASK) == `YARC_DMEM_BASE)
            sel_d = SEL_DMEM;
        else if ((bus_req_i.addr & `YARC_MTIMER_MASK) == `YARC_MTIMER_BASE)
            sel_d = SEL_TIMER;
        else if ((bus_req_i.addr & `YARC_LED_MASK) == `YARC_LED_BASE)
            sel_d = SEL_LED;
    end

    // while busy, cyc stays with the slave that still owes a response
    assign route = busy_q ? target_q : sel_d;

    always_comb
    begin
        dmem_req_o  = '0;
        timer_req_o = '0;
        led_req_o   = '0;

        case (route)
            SEL_DMEM:
            begin
                dmem_req_o     = bus_req_i;
                // no new strobe until the pending one is answered
                dmem_req_o.stb = bus_req_i.stb && !busy_q;
            end

            SEL_TIMER:
            begin
                timer_req_o     = bus_req_i;
                timer_req_o.stb = bus_req_i.stb && !busy_q;
            end

            SEL_LED:
            begin
                led_req_o     = bus_req_i;
                led_req_o.stb = bus_req_i.stb && !busy_q;
            end

            // unmapped, nothing leaves the decoder
            SEL_NONE:
            begin
                dmem_req_o = '0;
            end
        endcase
    end

    // response of the routed slave
    always_comb
    begin
        tgt_rsp = '0;

        case (route)
            SEL_DMEM:  tgt_rsp = dmem_rsp_i;
            SEL_TIMER: tgt_rsp = timer_rsp_i;
            SEL_LED:   tgt_rsp = led_rsp_i;
            // local error reply, one cycle after acceptance
            SEL_NONE:  tgt_rsp.err = busy_q;
        endcase
    end

    always_comb
    begin
        bus_rsp_o = '0;

        // slave stall passes up, plus our own while one access is open
        bus_rsp_o.stall = busy_q || tgt_rsp.stall;

        if (busy_q)
        begin
            bus_rsp_o.ack   = tgt_rsp.ack;
            bus_rsp_o.err   = tgt_rsp.err;
            bus_rsp_o.rdata = tgt_rsp.rdata;
        end
    end

    assign accept = bus_req_i.cyc && bus_req_i.stb && !bus_rsp_o.stall;
    assign done   = busy_q && (tgt_rsp.ack || tgt_rsp.err);

    // single outstanding access, so responses keep their order
    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            busy_q   <= 1'b0;
            target_q <= SEL_NONE;
        end
        else if (accept)
        begin
            busy_q   <= 1'b1;
            target_q <= sel_d;
        end
        else if (done)
        begin
            busy_q <= 1'b0;
        end
    end

endmodule : bus_decoder

`default_nettype wire

//--- src/mtimer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// machine timer, 64 bit mtime/mtimecmp
// and the timer interrupt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "yarc_defines.svh"

module mtimer
(
    input  logic                 clk_i,
    input  logic                 rstn_i,

    // slave port
    input  platform_pkg::wb_req_t req_i,
    output platform_pkg::wb_rsp_t rsp_o,

    output logic                 irq_timer_o
);
    localparam int unsigned PRESCALE = `YARC_MTIME_PRESCALE;
    localparam int unsigned PS_W     = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    logic [63:0]     mtime_q;
    logic [63:0]     mtimecmp_q;
    logic [PS_W-1:0] presc_q;
    logic            tick;
    logic            accept;
    logic [1:0]      reg_idx;
    logic [31:0]     rdata_d;
    logic [31:0]     rdata_q;
    logic            ack_q;
    logic            irq_q;

    // never stalls, every strobe is taken
    assign accept  = req_i.cyc && req_i.stb;
    assign reg_idx = req_i.addr[3:2];

    // prescaler, wraps once per mtime step
    assign tick = (presc_q == PS_W'(PRESCALE - 1));

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
            presc_q <= '0;
        else if (tick)
            presc_q <= '0;
        else
            presc_q <= presc_q + PS_W'(1);
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            mtime_q    <= '0;
            // all ones keeps the irq quiet until software arms it
            mtimecmp_q <= '1;
        end
        else
        begin
            if (tick)
                mtime_q <= mtime_q + 64'd1;

            // a bus write beats the increment on the written half
            if (accept && req_i.we)
            begin
                case (reg_idx)
                    `YARC_MTIME_LO_WORD:    mtime_q[31:0]     <= req_i.wdata;
                    `YARC_MTIME_HI_WORD:    mtime_q[63:32]    <= req_i.wdata;
                    `YARC_MTIMECMP_LO_WORD: mtimecmp_q[31:0]  <= req_i.wdata;
                    `YARC_MTIMECMP_HI_WORD: mtimecmp_q[63:32] <= req_i.wdata;
                endcase
            end
        end
    end

    // read mux
    always_comb
    begin
        case (reg_idx)
            `YARC_MTIME_LO_WORD:    rdata_d = mtime_q[31:0];
            `YARC_MTIME_HI_WORD:    rdata_d = mtime_q[63:32];
            `YARC_MTIMECMP_LO_WORD: rdata_d = mtimecmp_q[31:0];
            default:                rdata_d = mtimecmp_q[63:32];
        endcase
    end

    // value sampled at acceptance, shown with the ack
    always_ff @(posedge clk_i)
    begin
        if (accept)
            rdata_q <= rdata_d;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            ack_q <= 1'b0;
            irq_q <= 1'b0;
        end
        else
        begin
            ack_q <= accept;
            // level irq, follows the compare one cycle late
            irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    always_comb
    begin
        rsp_o       = '0;
        rsp_o.ack   = ack_q;
        rsp_o.rdata = rdata_q;
    end

    assign irq_timer_o = irq_q;

endmodule : mtimer

`default_nettype wire

//--- src/led_driver.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// led status register with read-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module led_driver
(
    input  logic                 clk_i,
    input  logic                 rstn_i,

    // slave port, one word
    input  platform_pkg::wb_req_t req_i,
    output platform_pkg::wb_rsp_t rsp_o,

    // to the board leds
    output logic [7:0]           led_status_o
);
    logic [7:0] status_q;
    logic       ack_q;
    logic       accept;

    // no stall, strobe always taken
    assign accept = req_i.cyc && req_i.stb;

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            status_q <= '0;
            ack_q    <= 1'b0;
        end
        else
        begin
            ack_q <= accept;
            // only byte 0 is stored
            if (accept && req_i.we)
                status_q <= req_i.wdata[7:0];
        end
    end

    // read-back, zero extended
    always_comb
    begin
        rsp_o       = '0;
        rsp_o.ack   = ack_q;
        rsp_o.rdata = {24'h0, status_q};
    end

    assign led_status_o = status_q;

endmodule : led_driver

`default_nettype wire

//--- src/yarc_platform.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// platform interconnect, two masters to
// dmem, machine timer and leds
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module yarc_platform
(
    input  logic                 clk_i,
    input  logic                 rstn_i,

    // bus masters
    input  platform_pkg::wb_req_t core_req_i,
    output platform_pkg::wb_rsp_t core_rsp_o,
    input  platform_pkg::wb_req_t dbg_req_i,
    output platform_pkg::wb_rsp_t dbg_rsp_o,

    // data memory lives outside
    output platform_pkg::wb_req_t dmem_req_o,
    input  platform_pkg::wb_rsp_t dmem_rsp_i,

    // peripheral outputs
    output logic [7:0]           led_status_o,
    output logic                 irq_timer_o
);
    import platform_pkg::*;

    // shared bus after arbitration
    wb_req_t bus_req;
    wb_rsp_t bus_rsp;

    // decoder to peripherals
    wb_req_t timer_req;
    wb_rsp_t timer_rsp;
    wb_req_t led_req;
    wb_rsp_t led_rsp;

    bus_arbiter u_arbiter
    (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .core_req_i (core_req_i),
        .core_rsp_o (core_rsp_o),
        .dbg_req_i  (dbg_req_i),
        .dbg_rsp_o  (dbg_rsp_o),
        .bus_req_o  (bus_req),
        .bus_rsp_i  (bus_rsp)
    );

    bus_decoder u_decoder
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .bus_req_i   (bus_req),
        .bus_rsp_o   (bus_rsp),
        .dmem_req_o  (dmem_req_o),
        .dmem_rsp_i  (dmem_rsp_i),
        .timer_req_o (timer_req),
        .timer_rsp_i (timer_rsp),
        .led_req_o   (led_req),
        .led_rsp_i   (led_rsp)
    );

    mtimer u_mtimer
    (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_i       (timer_req),
        .rsp_o       (timer_rsp),
        .irq_timer_o (irq_timer_o)
    );

    led_driver u_led_driver
    (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_i        (led_req),
        .rsp_o        (led_rsp),
        .led_status_o (led_status_o)
    );

endmodule : yarc_platform

`default_nettype wire

//--- bench/tb_yarc_platform.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// platform testbench with directed tests
// and a random latency data memory model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "yarc_defines.svh"

module tb_yarc_platform;
    import platform_pkg::*;

    localparam int          BUS_TIMEOUT   = 50;
    localparam int          IRQ_TIMEOUT   = 40;
    localparam logic [31:0] LED_ADDR      = `YARC_LED_BASE;
    localparam logic [31:0] MTIME_LO_ADDR = `YARC_MTIMER_BASE;
    localparam logic [31:0] MTIME_HI_ADDR = `YARC_MTIMER_BASE + 32'h4;
    localparam logic [31:0] CMP_LO_ADDR   = `YARC_MTIMER_BASE + 32'h8;
    localparam logic [31:0] CMP_HI_ADDR   = `YARC_MTIMER_BASE + 32'hC;
    localparam logic [31:0] HOLE_ADDR     = 32'h4000_0000;

    logic       clk;
    logic       rstn;
    wb_req_t    core_req;
    wb_rsp_t    core_rsp;
    wb_req_t    dbg_req;
    wb_rsp_t    dbg_rsp;
    wb_req_t    dmem_req;
    wb_rsp_t    dmem_rsp;
    logic [7:0] led_status;
    logic       irq_timer;

    // memory model words keyed by addr[31:2]
    logic [31:0] mem_words [logic [29:0]];
    wb_req_t     mem_req_q;
    int          stall_left;
    int          ack_delay;
    integer      seed = 32'h9f49a92c;

    // run bookkeeping
    int err_count     = 0;
    int check_count   = 0;
    int test_count    = 0;
    int fail_count    = 0;
    int test_err_base = 0;

    // words written by the dmem test and read back by debug later
    logic [31:0] dmem_addr [4];
    logic [31:0] dmem_data [4];

    // finished masters in the arbitration test, bit 0 core and bit 1 debug
    logic [1:0]  arb_done;

    yarc_platform u_dut
    (
        .clk_i        (clk),
        .rstn_i       (rstn),
        .core_req_i   (core_req),
        .core_rsp_o   (core_rsp),
        .dbg_req_i    (dbg_req),
        .dbg_rsp_o    (dbg_rsp),
        .dmem_req_o   (dmem_req),
        .dmem_rsp_i   (dmem_rsp),
        .led_status_o (led_status),
        .irq_timer_o  (irq_timer)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [1:0] random_0_to_3();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0];
    endfunction

    // unwritten words read back a pattern built from the address
    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        if (mem_words.exists(addr[31:2]))
            return mem_words[addr[31:2]];
        return addr ^ 32'hA5C3_0F69;
    endfunction

    task automatic mem_write(input wb_req_t r);
        logic [31:0] word;
        word = mem_read(r.addr);
        for (int b = 0; b < 4; b++)
        begin
            if (r.sel[b])
                word[8*b +: 8] = r.wdata[8*b +: 8];
        end
        mem_words[r.addr[31:2]] = word;
    endtask

    // dmem slave with 0-3 stall cycles per request and an ack 1-4 cycles after accept
    initial
    begin
        dmem_rsp       = '0;
        stall_left     = int'(random_0_to_3());
        dmem_rsp.stall = (stall_left != 0);
        forever
        begin
            @(negedge clk);
            if (dmem_req.cyc && dmem_req.stb)
            begin
                if (dmem_rsp.stall)
                begin
                    @(posedge clk);
                    #1;
                    stall_left     = stall_left - 1;
                    dmem_rsp.stall = (stall_left != 0);
                end
                else
                begin
                    mem_req_q = dmem_req;
                    ack_delay = 1 + int'(random_0_to_3());
                    // acceptance edge followed by the remaining delay
                    @(posedge clk);
                    repeat (ack_delay - 1) @(posedge clk);
                    #1;
                    if (mem_req_q.we)
                        mem_write(mem_req_q);
                    dmem_rsp.ack   = 1'b1;
                    dmem_rsp.rdata = mem_req_q.we ? 32'h0 : mem_read(mem_req_q.addr);
                    @(posedge clk);
                    #1;
                    dmem_rsp.ack   = 1'b0;
                    dmem_rsp.rdata = '0;
                    stall_left     = int'(random_0_to_3());
                    dmem_rsp.stall = (stall_left != 0);
                end
            end
        end
    end

    task end_run;
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, fail_count, check_count, err_count);
        if (err_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        err_count++;
        $display("timeout at %0t: %s got no response within %0d cycles",
                 $time, what, BUS_TIMEOUT);
        end_run();
    endtask

    task automatic begin_test;
        test_err_base = err_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count == test_err_base)
        begin
            $display("test %s: pass", name);
        end
        else
        begin
            fail_count++;
            $display("test %s: FAIL, %0d errors", name, err_count - test_err_base);
        end
    endtask

    task automatic check_rsp(input string what, input wb_rsp_t got, input wb_rsp_t exp);
        check_count++;
        if (got.ack !== exp.ack || got.err !== exp.err)
        begin
            err_count++;
            $display("** Error at %0t: %s ack/err expected %b/%b got %b/%b",
                     $time, what, exp.ack, exp.err, got.ack, got.err);
        end
    endtask

    task automatic check_data(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("** Error at %0t: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    task automatic check_leds(input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("** Error at %0t: led_status_o expected %h got %h", $time, exp, got);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("** Error at %0t: %s expected %b got %b", $time, what, exp, got);
        end
    endtask

    function automatic wb_rsp_t expect_rsp(input logic ack, input logic err);
        wb_rsp_t r;
        r     = '0;
        r.ack = ack;
        r.err = err;
        return r;
    endfunction

    task automatic drive_req(input bus_owner_e m, input wb_req_t req);
        if (m == OWN_CORE)
            core_req = req;
        else
            dbg_req = req;
    endtask

    function automatic wb_rsp_t port_rsp(input bus_owner_e m);
        return (m == OWN_CORE) ? core_rsp : dbg_rsp;
    endfunction

    // one pipelined access that starts and ends 1 ns after a rising edge
    task automatic bus_access(input bus_owner_e m, input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, output wb_rsp_t rsp);
        wb_req_t req;
        wb_rsp_t cur;
        logic    accepted;
        logic    done;
        int      waited;
        req       = '0;
        req.cyc   = 1'b1;
        req.stb   = 1'b1;
        req.we    = we;
        req.addr  = addr;
        req.sel   = 4'hF;
        req.wdata = wdata;
        drive_req(m, req);
        // hold stb through stall while no response may show up yet
        accepted = 1'b0;
        waited   = 0;
        while (!accepted)
        begin
            @(negedge clk);
            cur = port_rsp(m);
            if (cur.ack || cur.err)
            begin
                err_count++;
                $display("stray ack or err on the %s port at %0t before its request was taken",
                         m.name(), $time);
            end
            accepted = !cur.stall;
            waited++;
            if (!accepted && waited >= BUS_TIMEOUT)
                abort_on_timeout("request still stalled");
        end
        @(posedge clk);
        #1;
        req.stb = 1'b0;
        drive_req(m, req);
        // cyc stays up until ack or err
        done   = 1'b0;
        waited = 0;
        while (!done)
        begin
            @(negedge clk);
            cur  = port_rsp(m);
            done = cur.ack || cur.err;
            waited++;
            if (!done && waited >= BUS_TIMEOUT)
                abort_on_timeout("accepted request");
        end
        rsp = cur;
        @(posedge clk);
        #1;
        drive_req(m, '0);
    endtask

    task automatic bus_write(input bus_owner_e m, input logic [31:0] addr,
                             input logic [31:0] data, output wb_rsp_t rsp);
        bus_access(m, 1'b1, addr, data, rsp);
    endtask

    task automatic bus_read(input bus_owner_e m, input logic [31:0] addr,
                            output logic [31:0] data, output wb_rsp_t rsp);
        bus_access(m, 1'b0, addr, 32'h0, rsp);
        data = rsp.rdata;
    endtask

    // a finished master must see no ack or err while the other one is served
    task automatic watch_port_quiet(input bus_owner_e m);
        wb_rsp_t cur;
        int      waited;
        waited = 0;
        while (arb_done != 2'b11)
        begin
            @(negedge clk);
            cur = port_rsp(m);
            if (cur.ack || cur.err)
            begin
                err_count++;
                $display("ack or err on the %s port at %0t for the other master's request",
                         m.name(), $time);
            end
            waited++;
            if (arb_done != 2'b11 && waited >= BUS_TIMEOUT)
                abort_on_timeout("other master");
        end
    endtask

    task automatic test_reset_state;
        wb_rsp_t     rsp;
        logic [31:0] data;
        begin_test();
        check_leds(led_status, 8'h00);
        check_flag("irq_timer_o", irq_timer, 1'b0);
        check_rsp("core_rsp_o", core_rsp, expect_rsp(1'b0, 1'b0));
        check_flag("core_rsp_o.stall", core_rsp.stall, 1'b0);
        check_rsp("dbg_rsp_o", dbg_rsp, expect_rsp(1'b0, 1'b0));
        check_flag("dbg_rsp_o.stall", dbg_rsp.stall, 1'b0);
        check_flag("dmem_req_o.cyc", dmem_req.cyc, 1'b0);
        check_flag("dmem_req_o.stb", dmem_req.stb, 1'b0);
        bus_read(OWN_CORE, CMP_LO_ADDR, data, rsp);
        check_rsp("mtimecmp_lo read", rsp, expect_rsp(1'b1, 1'b0));
        check_data("mtimecmp_lo", data, 32'hFFFF_FFFF);
        bus_read(OWN_CORE, CMP_HI_ADDR, data, rsp);
        check_rsp("mtimecmp_hi read", rsp, expect_rsp(1'b1, 1'b0));
        check_data("mtimecmp_hi", data, 32'hFFFF_FFFF);
        end_test("reset_state");
    endtask

    task automatic test_led_access;
        wb_rsp_t     rsp;
        logic [31:0] data;
        begin_test();
        bus_write(OWN_CORE, LED_ADDR, 32'h0000_00A5, rsp);
        check_rsp("led write", rsp, expect_rsp(1'b1, 1'b0));
        check_leds(led_status, 8'hA5);
        bus_read(OWN_CORE, LED_ADDR, data, rsp);
        check_rsp("led read", rsp, expect_rsp(1'b1, 1'b0));
        check_data("led read-back", data, 32'h0000_00A5);
        end_test("led_access");
    endtask

    task automatic test_dmem_access;
        wb_rsp_t     rsp;
        logic [31:0] data;
        begin_test();
        // spread over the region up to its last word
        dmem_addr[0] = 32'h1000_0010;
        dmem_addr[1] = 32'h1000_0104;
        dmem_addr[2] = 32'h1ABC_0008;
        dmem_addr[3] = 32'h1FFF_FFFC;
        for (int i = 0; i < 4; i++)
        begin
            dmem_data[i] = $random(seed);
            bus_write(OWN_CORE, dmem_addr[i], dmem_data[i], rsp);
            check_rsp("dmem write", rsp, expect_rsp(1'b1, 1'b0));
        end
        for (int i = 0; i < 4; i++)
        begin
            bus_read(OWN_CORE, dmem_addr[i], data, rsp);
            check_rsp("dmem read", rsp, expect_rsp(1'b1, 1'b0));
            check_data("dmem rdata", data, dmem_data[i]);
        end
        end_test("dmem_access");
    endtask

    task automatic test_timer_irq;
        wb_rsp_t     rsp;
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] hi;
        logic [63:0] target;
        int          waited;
        begin_test();
        bus_read(OWN_CORE, MTIME_LO_ADDR, first, rsp);
        bus_read(OWN_CORE, MTIME_LO_ADDR, second, rsp);
        check_flag("mtime_lo increasing", second > first, 1'b1);
        bus_read(OWN_CORE, MTIME_LO_ADDR, first, rsp);
        bus_read(OWN_CORE, MTIME_HI_ADDR, hi, rsp);
        target = {hi, first} + 64'd20;
        // low half first so the compare never drops below mtime early
        bus_write(OWN_CORE, CMP_LO_ADDR, target[31:0], rsp);
        bus_write(OWN_CORE, CMP_HI_ADDR, target[63:32], rsp);
        check_flag("irq_timer_o after arm", irq_timer, 1'b0);
        waited = 0;
        while (!irq_timer && waited < IRQ_TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!irq_timer)
        begin
            err_count++;
            $display("irq_timer_o did not rise within %0d cycles", IRQ_TIMEOUT);
        end
        @(posedge clk);
        #1;
        bus_write(OWN_CORE, CMP_LO_ADDR, 32'hFFFF_FFFF, rsp);
        bus_write(OWN_CORE, CMP_HI_ADDR, 32'hFFFF_FFFF, rsp);
        @(negedge clk);
        check_flag("irq_timer_o after disarm", irq_timer, 1'b0);
        @(posedge clk);
        #1;
        end_test("timer_irq");
    endtask

    task automatic test_unmapped;
        wb_rsp_t     rsp;
        logic [31:0] data;
        begin_test();
        bus_read(OWN_CORE, HOLE_ADDR, data, rsp);
        check_rsp("unmapped read", rsp, expect_rsp(1'b0, 1'b1));
        end_test("unmapped");
    endtask

    task automatic test_arbitration;
        wb_rsp_t     core_r;
        wb_rsp_t     dbg_r;
        logic [31:0] core_data;
        logic [31:0] dbg_data;
        begin_test();
        arb_done = 2'b00;
        // one idle cycle so the arbiter sees a real tie
        @(posedge clk);
        #1;
        fork
            begin
                bus_read(OWN_CORE, LED_ADDR, core_data, core_r);
                arb_done[0] = 1'b1;
                watch_port_quiet(OWN_CORE);
            end
            begin
                bus_read(OWN_DBG, dmem_addr[0], dbg_data, dbg_r);
                arb_done[1] = 1'b1;
                watch_port_quiet(OWN_DBG);
            end
        join
        check_rsp("core led read", core_r, expect_rsp(1'b1, 1'b0));
        check_data("core led rdata", core_data, 32'h0000_00A5);
        check_rsp("debug dmem read", dbg_r, expect_rsp(1'b1, 1'b0));
        check_data("debug dmem rdata", dbg_data, dmem_data[0]);
        end_test("arbitration");
    endtask

    initial
    begin
        core_req = '0;
        dbg_req  = '0;
        rstn     = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        test_reset_state();
        test_led_access();
        test_dmem_access();
        test_timer_irq();
        test_unmapped();
        test_arbitration();
        end_run();
    end

endmodule : tb_yarc_platform

`default_nettype wire

//--- yarc_platform.f
+incdir+include
src/platform_pkg.sv
src/bus_arbiter.sv
src/bus_decoder.sv
src/mtimer.sv
src/led_driver.sv
src/yarc_platform.sv
bench/tb_yarc_platform.sv

//--- run_sim.sh
#!/bin/sh
# build and run the platform testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
    -f yarc_platform.f --top-module tb_yarc_platform \
    -Mdir obj_dir -o sim_yarc

./obj_dir/sim_yarc > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
